// ==== hw/lsu_config.svh ====
////////////////////////////////////////
// LSU subsystem configuration
// Data path width and data memory size
////////////////////////////////////////

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data and address width in bits
`define LSU_XLEN 32

// Data memory depth in 32-bit words
// Keep a power of two, the index is cut from the word address
`define LSU_MEM_WORDS 256

`endif

// ==== hw/rv_isa_pkg.sv ====
////////////////////////////////////////
// RV32I ISA definitions
// Opcodes, control word layout, access sizes
////////////////////////////////////////

`default_nettype none

package rv_isa_pkg;

    // Base integer opcodes
    typedef enum logic [6:0] {
        OP_R_TYPE  = 7'b0110011,  // Register arithmetic
        OP_I_ARITH = 7'b0010011,  // Immediate arithmetic
        OP_LOAD    = 7'b0000011,
        OP_JALR    = 7'b1100111,
        OP_SYSTEM  = 7'b1110011,  // ECALL / EBREAK / CSR
        OP_STORE   = 7'b0100011,
        OP_BRANCH  = 7'b1100011,
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111
    } opcode_e;

    // Load/store access size
    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,  // Not a memory access, or bad func3
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } data_size_e;

    // ALU operation class
    localparam logic [1:0] ALU_OP_ADD    = 2'b00;
    localparam logic [1:0] ALU_OP_BRANCH = 2'b01;
    localparam logic [1:0] ALU_OP_FUNC   = 2'b10;  // From func3/func7

    // Control word, 11 bits, reg_write is bit 0
    typedef struct packed {
        data_size_e data_size;   // [10:9]
        logic [1:0] alu_op;      // [8:7]
        logic       jump;        // [6]
        logic       branch;      // [5]
        logic       mem_to_reg;  // [4]
        logic       alu_src;     // [3]
        logic       mem_write;   // [2]
        logic       mem_read;    // [1]
        logic       reg_write;   // [0]
    } ctrl_t;

endpackage

`default_nettype wire

// ==== hw/mem_bus_pkg.sv ====
////////////////////////////////////////
// Shared data memory bus types
// Request and completion structs
////////////////////////////////////////

`default_nettype none

`include "lsu_config.svh"

package mem_bus_pkg;

    // One memory request, word addressed
    typedef struct packed {
        logic                   write;  // 1 = store, 0 = load
        logic [`LSU_XLEN-3:0]   addr;   // Word address
        logic [3:0]             be;     // Byte lane enables
        logic [`LSU_XLEN-1:0]   wdata;  // Lane-aligned write data
    } mem_req_t;

    // One completion
    typedef struct packed {
        logic                   done;   // Single-cycle pulse
        logic [`LSU_XLEN-1:0]   rdata;  // Raw word from memory
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== hw/base_integer_ctrl_unit.sv ====
////////////////////////////////////////
// Base integer control unit
// Decodes opcode and func3 into the
// pipeline control word
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module base_integer_ctrl_unit (
    input  wire  [6:0]          i_opcode,  // Instruction opcode field
    input  wire  [2:0]          i_func3,   // Instruction func3 field
    output rv_isa_pkg::ctrl_t   o_ctrl     // Decoded control word
);

    import rv_isa_pkg::*;

    ////////////////////////////////////////
    // Decode table
    ////////////////////////////////////////

    always_comb begin
        o_ctrl = '0;  // Unknown opcode gives all zero
        case (i_opcode)
            OP_R_TYPE: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = ALU_OP_FUNC;
            end
            OP_I_ARITH, OP_JALR, OP_SYSTEM: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;                       // Immediate operand
                o_ctrl.jump      = (i_opcode == OP_JALR);
                // Environment calls do not use func3 for the ALU
                o_ctrl.alu_op    = (i_opcode == OP_SYSTEM) ? ALU_OP_ADD : ALU_OP_FUNC;
            end
            OP_LOAD: begin
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.alu_src    = 1'b1;
                o_ctrl.mem_to_reg = 1'b1;                      // Write back load data
                o_ctrl.alu_op     = ALU_OP_ADD;                // Address add
                case (i_func3)
                    3'b000:  o_ctrl.data_size = SIZE_BYTE;     // LB
                    3'b001:  o_ctrl.data_size = SIZE_HALF;     // LH
                    3'b010:  o_ctrl.data_size = SIZE_WORD;     // LW
                    3'b100:  o_ctrl.data_size = SIZE_BYTE;     // LBU
                    3'b101:  o_ctrl.data_size = SIZE_HALF;     // LHU
                    default: o_ctrl.data_size = SIZE_NONE;     // Reserved func3
                endcase
            end
            OP_STORE: begin
                o_ctrl.mem_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_op    = ALU_OP_ADD;
                case (i_func3)
                    3'b000:  o_ctrl.data_size = SIZE_BYTE;     // SB
                    3'b001:  o_ctrl.data_size = SIZE_HALF;     // SH
                    3'b010:  o_ctrl.data_size = SIZE_WORD;     // SW
                    default: o_ctrl.data_size = SIZE_NONE;
                endcase
            end
            OP_BRANCH: begin
                o_ctrl.branch = 1'b1;
                o_ctrl.alu_op = ALU_OP_BRANCH;                 // Compare
            end
            OP_LUI, OP_AUIPC: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_op    = ALU_OP_ADD;
            end
            OP_JAL: begin
                o_ctrl.reg_write = 1'b1;                       // Link register
                o_ctrl.jump      = 1'b1;
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/imm_gen.sv ====
////////////////////////////////////////
// Immediate generator
// Sign-extended I-type or S-type imm
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module imm_gen (
    input  wire  [`LSU_XLEN-1:0] i_instr,  // Full instruction word
    output logic [`LSU_XLEN-1:0] o_imm     // Sign-extended immediate
);

    import rv_isa_pkg::*;

    logic [11:0] imm12;  // Raw 12-bit field
    logic        is_store;

    assign is_store = (i_instr[6:0] == OP_STORE);

    // S-type splits the field around rd
    always_comb begin
        if (is_store) begin
            imm12 = {i_instr[31:25], i_instr[11:7]};
        end else begin
            imm12 = i_instr[31:20];  // I-type, loads and the rest
        end
    end

    // Bit 31 of the instruction is the sign in both formats
    assign o_imm = {{(`LSU_XLEN-12){imm12[11]}}, imm12};

endmodule

`default_nettype wire

// ==== hw/load_store_unit.sv ====
////////////////////////////////////////
// Load/store unit
// Address generation, byte lanes, store
// alignment and load extension
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module load_store_unit (
    input  wire                          clk,
    input  wire                          i_rst_n,
    input  wire                          i_instr_valid,  // One-cycle instruction strobe
    input  wire rv_isa_pkg::ctrl_t       i_ctrl,
    input  wire  [2:0]                   i_func3,
    input  wire  [`LSU_XLEN-1:0]         i_rs1,          // Base address
    input  wire  [`LSU_XLEN-1:0]         i_rs2,          // Store data
    input  wire  [`LSU_XLEN-1:0]         i_imm,          // Offset
    input  wire                          i_grant,        // From arbiter
    input  wire mem_bus_pkg::mem_rsp_t   i_rsp,          // Routed completion
    output logic                         o_req_valid,    // Held until granted
    output mem_bus_pkg::mem_req_t        o_req,
    output mem_bus_pkg::mem_rsp_t        o_lsu_rsp,      // Extended load data
    output logic                         o_busy
);

    import rv_isa_pkg::*;

    logic [`LSU_XLEN-1:0] eff_addr;
    logic [1:0]           byte_off;
    logic [3:0]           byte_en;
    logic [`LSU_XLEN-1:0] wr_data;
    logic                 mem_access;
    logic                 accept;

    logic [2:0]           func3_q;  // Bit 2 selects zero extension
    logic [1:0]           off_q;
    data_size_e           size_q;

    logic [`LSU_XLEN-1:0] lane;
    logic [`LSU_XLEN-1:0] ld_data;

    ////////////////////////////////////////
    // Address generation and lanes
    ////////////////////////////////////////

    assign eff_addr   = i_rs1 + i_imm;
    assign byte_off   = eff_addr[1:0];
    assign mem_access = i_ctrl.mem_read | i_ctrl.mem_write;
    assign accept     = i_instr_valid & mem_access & ~o_busy;
    assign wr_data    = i_rs2 << {byte_off, 3'b000};  // Move into the addressed lane

    always_comb begin
        case (i_ctrl.data_size)
            SIZE_BYTE: byte_en = 4'b0001 << byte_off;
            SIZE_HALF: byte_en = 4'b0011 << byte_off;
            SIZE_WORD: byte_en = 4'b1111;
            default:   byte_en = 4'b0000;  // Bad func3, no lanes touched
        endcase
    end

    ////////////////////////////////////////
    // Request and busy control
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_req_valid <= 1'b0;
            o_busy      <= 1'b0;
        end else if (accept) begin
            o_req_valid <= 1'b1;
            o_busy      <= 1'b1;
        end else begin
            if (i_grant) begin
                o_req_valid <= 1'b0;  // Memory has it now
            end
            if (i_rsp.done) begin
                o_busy <= 1'b0;
            end
        end
    end

    // Payload, held through the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            o_req.write <= i_ctrl.mem_write;
            o_req.addr  <= eff_addr[`LSU_XLEN-1:2];
            o_req.be    <= byte_en;
            o_req.wdata <= wr_data;
            func3_q     <= i_func3;
            off_q       <= byte_off;
            size_q      <= i_ctrl.data_size;
        end
    end

    ////////////////////////////////////////
    // Load extension
    ////////////////////////////////////////

    assign lane = i_rsp.rdata >> {off_q, 3'b000};  // Addressed lane to bit 0

    always_comb begin
        case (size_q)
            SIZE_BYTE: ld_data = {{(`LSU_XLEN-8){lane[7] & ~func3_q[2]}}, lane[7:0]};
            SIZE_HALF: ld_data = {{(`LSU_XLEN-16){lane[15] & ~func3_q[2]}}, lane[15:0]};
            default:   ld_data = lane;
        endcase
    end

    assign o_lsu_rsp.done  = i_rsp.done;
    assign o_lsu_rsp.rdata = o_req.write ? '0 : ld_data;  // Stores return zero

    // Misaligned accesses are outside this design
    a_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_instr_valid && mem_access) |->
            ((i_ctrl.data_size != SIZE_HALF || !byte_off[0]) &&
             (i_ctrl.data_size != SIZE_WORD || byte_off == 2'b00)));

    // Upstream must wait for done
    a_no_instr_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_instr_valid |-> !o_busy);

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
////////////////////////////////////////
// Two-port round-robin memory arbiter
// Forwards one payload, routes completion
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
    parameter type PAYLOAD_T = mem_bus_pkg::mem_req_t
) (
    input  wire                          clk,
    input  wire                          i_rst_n,
    input  wire  [1:0]                   i_req_valid,  // Port 0 LSU, port 1 host
    input  var   PAYLOAD_T               i_req [2],
    input  wire mem_bus_pkg::mem_rsp_t   i_mem_rsp,    // One cycle after grant
    output logic [1:0]                   o_grant,
    output PAYLOAD_T                     o_mem_req,
    output logic                         o_mem_valid,
    output mem_bus_pkg::mem_rsp_t        o_rsp [2]
);

    logic [1:0] eligible;
    logic [1:0] gnt_q;    // Grant of the previous cycle
    logic       last_q;   // Last winner
    logic       win_idx;

    // A port with a response in flight sits out one cycle
    assign eligible = i_req_valid & ~gnt_q;

    always_comb begin
        if (eligible == 2'b11) begin
            win_idx = ~last_q;  // Alternate under contention
        end else begin
            win_idx = eligible[1];
        end
    end

    assign o_grant     = (eligible == 2'b00) ? 2'b00 : (2'b01 << win_idx);
    assign o_mem_valid = |o_grant;
    assign o_mem_req   = i_req[win_idx];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gnt_q  <= 2'b00;
            last_q <= 1'b1;  // LSU wins first
        end else begin
            gnt_q <= o_grant;
            if (o_mem_valid) begin
                last_q <= win_idx;
            end
        end
    end

    // Completion goes back to last cycle's winner only
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            o_rsp[i].done  = i_mem_rsp.done & gnt_q[i];
            o_rsp[i].rdata = i_mem_rsp.rdata;
        end
    end

    // Each memory completion belongs to exactly one granted port
    a_grant_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_rsp.done |-> $onehot(gnt_q));

    // Memory must answer every grant on the next cycle
    a_rsp_follows: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_mem_valid |=> i_mem_rsp.done);

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
////////////////////////////////////////
// Data memory
// Byte-enabled writes, registered reads
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module data_mem (
    input  wire                          clk,
    input  wire                          i_rst_n,
    input  wire                          i_valid,  // Granted request this cycle
    input  wire mem_bus_pkg::mem_req_t   i_req,
    output mem_bus_pkg::mem_rsp_t        o_rsp
);

    localparam int ADDR_W = $clog2(`LSU_MEM_WORDS);

    logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];
    logic [ADDR_W-1:0]    idx;      // Upper word address bits ignored
    logic [`LSU_XLEN-1:0] rdata_q;
    logic                 done_q;

    assign idx = i_req.addr[ADDR_W-1:0];

    // Read returns the word as it was before a write
    always_ff @(posedge clk) begin
        if (i_valid) begin
            if (i_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_req.be[b]) begin
                        mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= i_valid;  // Every request completes next cycle
        end
    end

    assign o_rsp.done  = done_q;
    assign o_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hw/lsu_subsys.sv ====
////////////////////////////////////////
// LSU subsystem top level
// Decode, LSU and host port sharing one
// data memory through an arbiter
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_subsys (
    input  wire                          clk,
    input  wire                          i_rst_n,
    input  wire                          i_instr_valid,
    input  wire  [`LSU_XLEN-1:0]         i_instr,
    input  wire  [`LSU_XLEN-1:0]         i_rs1,
    input  wire  [`LSU_XLEN-1:0]         i_rs2,
    input  wire mem_bus_pkg::mem_req_t   i_host_req,       // Held until done
    input  wire                          i_host_req_valid,
    output rv_isa_pkg::ctrl_t            o_ctrl,
    output mem_bus_pkg::mem_rsp_t        o_lsu_rsp,
    output logic                         o_busy,
    output mem_bus_pkg::mem_rsp_t        o_host_rsp
);

    import mem_bus_pkg::*;

    logic [`LSU_XLEN-1:0] imm;
    logic                 lsu_req_valid;
    mem_req_t             lsu_req;
    mem_req_t             arb_req [2];  // 0 LSU, 1 host
    mem_rsp_t             arb_rsp [2];
    logic [1:0]           arb_grant;
    mem_req_t             mem_req;
    logic                 mem_valid;
    mem_rsp_t             mem_rsp;

    assign arb_req[0] = lsu_req;
    assign arb_req[1] = i_host_req;
    assign o_host_rsp = arb_rsp[1];

    base_integer_ctrl_unit ctrl_unit_i (
        .i_opcode (i_instr[6:0]),
        .i_func3  (i_instr[14:12]),
        .o_ctrl   (o_ctrl)
    );

    imm_gen imm_gen_i (
        .i_instr (i_instr),
        .o_imm   (imm)
    );

    load_store_unit lsu_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_ctrl        (o_ctrl),
        .i_func3       (i_instr[14:12]),
        .i_rs1         (i_rs1),
        .i_rs2         (i_rs2),
        .i_imm         (imm),
        .i_grant       (arb_grant[0]),
        .i_rsp         (arb_rsp[0]),
        .o_req_valid   (lsu_req_valid),
        .o_req         (lsu_req),
        .o_lsu_rsp     (o_lsu_rsp),
        .o_busy        (o_busy)
    );

    mem_arbiter #(
        .PAYLOAD_T (mem_req_t)
    ) arbiter_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid ({i_host_req_valid, lsu_req_valid}),
        .i_req       (arb_req),
        .i_mem_rsp   (mem_rsp),
        .o_grant     (arb_grant),
        .o_mem_req   (mem_req),
        .o_mem_valid (mem_valid),
        .o_rsp       (arb_rsp)
    );

    data_mem data_mem_i (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_valid (mem_valid),
        .i_req   (mem_req),
        .o_rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== verif/tb_lsu_subsys.sv ====
////////////////////////////////////////
// LSU subsystem testbench
// Record-driven stimulus, memory model,
// latency and contention checks
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module tb_lsu_subsys;

    import rv_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int REC_W    = 9;   // Words per record
    localparam int MAX_RECS = 64;
    localparam int AW       = $clog2(`LSU_MEM_WORDS);

    logic                 clk;
    logic                 i_rst_n;
    logic                 i_instr_valid;
    logic [`LSU_XLEN-1:0] i_instr;
    logic [`LSU_XLEN-1:0] i_rs1;
    logic [`LSU_XLEN-1:0] i_rs2;
    mem_req_t             i_host_req;
    logic                 i_host_req_valid;
    ctrl_t                o_ctrl;
    mem_rsp_t             o_lsu_rsp;
    logic                 o_busy;
    mem_rsp_t             o_host_rsp;

    logic [31:0] recs  [REC_W*MAX_RECS];  // Raw file words
    logic [31:0] model [`LSU_MEM_WORDS];  // Expected memory contents
    logic [31:0] lfsr;
    int          n_recs;
    int          cycle_count;

    lsu_subsys lsu_subsys_i (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_instr_valid    (i_instr_valid),
        .i_instr          (i_instr),
        .i_rs1            (i_rs1),
        .i_rs2            (i_rs2),
        .i_host_req       (i_host_req),
        .i_host_req_valid (i_host_req_valid),
        .o_ctrl           (o_ctrl),
        .o_lsu_rsp        (o_lsu_rsp),
        .o_busy           (o_busy),
        .o_host_rsp       (o_host_rsp)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Galois LFSR step for one bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
    endfunction

    task automatic next_random(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w    = {w[30:0], lfsr[0]};  // Take one bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    // I-type offset or S-type for stores
    function automatic logic [31:0] instr_imm(input logic [31:0] ins);
        logic [11:0] f;
        f = (ins[6:0] == 7'b0100011) ? {ins[31:25], ins[11:7]} : ins[31:20];
        return {{20{f[11]}}, f};
    endfunction

    // LB/LH/LW sign extend and LBU/LHU zero extend
    function automatic logic [31:0] model_load(input logic [31:0] addr, input logic [2:0] f3);
        logic [31:0] w;
        w = model[addr[AW+1:2]] >> (8 * addr[1:0]);
        case (f3)
            3'd0:    return {{24{w[7]}}, w[7:0]};
            3'd1:    return {{16{w[15]}}, w[15:0]};
            3'd4:    return {24'h0, w[7:0]};
            3'd5:    return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic model_store(input logic [31:0] addr, input logic [2:0] f3,
                               input logic [31:0] data);
        int nbytes;
        nbytes = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
        for (int b = 0; b < nbytes; b++) begin
            model[addr[AW+1:2]][8*(addr[1:0]+b) +: 8] = data[8*b +: 8];  // Low bytes of rs2
        end
    endtask

    ////////////////////////////////////////
    // Record execution for all four kinds
    ////////////////////////////////////////

    task automatic run_record(input int r);
        logic [31:0] f [REC_W];
        logic [31:0] rs2;
        logic [31:0] addr;
        logic [31:0] lsu_data;
        logic [31:0] host_data;
        logic        use_lsu;
        logic        use_host;
        logic        lsu_mem;
        logic        finished;
        int          cyc;
        int          lsu_at;
        int          host_at;
        mem_req_t    hreq;
        for (int k = 0; k < REC_W; k++) begin
            f[k] = recs[REC_W*r + k];
        end
        next_random(rs2);
        rs2        = rs2 ^ f[3];  // File bits flip the random data
        use_lsu    = (f[0] == 1) || (f[0] == 3);
        use_host   = (f[0] == 2) || (f[0] == 3);
        lsu_mem    = use_lsu && (f[1][6:0] == 7'b0000011 || f[1][6:0] == 7'b0100011);
        addr       = f[2] + instr_imm(f[1]);
        hreq.write = f[4][0];
        hreq.addr  = f[5][29:0];
        hreq.be    = f[6][3:0];
        hreq.wdata = f[7];
        lsu_at     = 0;
        host_at    = 0;
        lsu_data   = '0;
        host_data  = '0;

        @(negedge clk);
        i_instr       = f[1];
        i_rs1         = f[2];
        i_rs2         = rs2;
        i_instr_valid = use_lsu;  // Kind 0 only decodes
        if (f[0] == 2) begin
            i_host_req       = hreq;
            i_host_req_valid = 1'b1;
        end
        @(posedge clk);
        if (f[0] != 2) begin
            check("o_ctrl", o_ctrl, f[8]);  // Same-cycle decode
        end

        cyc      = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            cyc++;
            i_instr_valid = 1'b0;
            if (f[0] == 3 && cyc == 1) begin
                // Host request meets the latched LSU request at the arbiter
                i_host_req       = hreq;
                i_host_req_valid = 1'b1;
            end
            if (lsu_mem && cyc == 1) check("o_busy", o_busy, 1);
            if (lsu_mem && lsu_at != 0) begin
                check("o_busy", o_busy, 0);  // Idle again after done
                check("o_lsu_rsp.done", o_lsu_rsp.done, 0);
            end
            if (!lsu_mem) begin
                check("o_busy", o_busy, 0);
                check("o_lsu_rsp.done", o_lsu_rsp.done, 0);
            end
            if (!use_host) check("o_host_rsp.done", o_host_rsp.done, 0);
            if (lsu_mem && lsu_at == 0 && o_lsu_rsp.done) begin
                lsu_at   = cyc;
                lsu_data = o_lsu_rsp.rdata;
            end
            if (use_host && host_at == 0 && o_host_rsp.done) begin
                host_at          = cyc;
                host_data        = o_host_rsp.rdata;
                i_host_req_valid = 1'b0;  // Release after done
            end
            finished = (cyc >= 3) && (!lsu_mem || lsu_at != 0) && (!use_host || host_at != 0);
        end

        // Latency is fixed when alone and bounded when sharing
        if (f[0] == 1 && lsu_mem) check("lsu done latency", lsu_at, 2);
        if (f[0] == 2) check("host done latency", host_at, 1);
        if (f[0] == 3 && (lsu_at > 3 || host_at > 3)) begin
            stop_on_error("A done pulse came more than 3 cycles after the start");
        end
        if (f[0] == 3 && lsu_mem && lsu_at == host_at) begin
            stop_on_error("LSU and host done pulses came in the same cycle");
        end

        // Compare data with the model before it takes the writes
        if (use_host && !hreq.write) begin
            check("o_host_rsp.rdata", host_data, model[hreq.addr[AW-1:0]]);
        end
        if (lsu_mem && !f[1][5]) begin
            check("o_lsu_rsp.rdata", lsu_data, model_load(addr, f[1][14:12]));
        end
        if (use_host && hreq.write) begin
            for (int b = 0; b < 4; b++) begin
                if (hreq.be[b]) model[hreq.addr[AW-1:0]][8*b +: 8] = hreq.wdata[8*b +: 8];
            end
        end
        if (lsu_mem && f[1][5]) model_store(addr, f[1][14:12], rs2);  // Opcode bit 5 marks store
    endtask

    ////////////////////////////////////////
    // Clock, watchdog and main sequence
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
        end
    end

    initial begin
        wait (n_recs > 0);
        wait (cycle_count >= 20 * n_recs + 50);
        stop_on_error("Timeout, the records did not finish within the cycle limit");
    end

    initial begin
        i_rst_n          = 1'b0;
        i_instr_valid    = 1'b0;
        i_instr          = '0;
        i_rs1            = '0;
        i_rs2            = '0;
        i_host_req       = '0;
        i_host_req_valid = 1'b0;
        lfsr             = 32'd77;  // Seed
        n_recs           = 0;
        $readmemh("verif/lsu_input.txt", recs);
        while (n_recs < MAX_RECS && !$isunknown(recs[REC_W*n_recs])) begin
            n_recs++;
        end
        if (n_recs == 0) stop_on_error("No records were read from the stimulus file");
        repeat (3) @(negedge clk);
        i_rst_n = 1'b1;
        check("o_busy", o_busy, 0);  // Idle after reset
        check("o_lsu_rsp.done", o_lsu_rsp.done, 0);
        check("o_host_rsp.done", o_host_rsp.done, 0);
        for (int r = 0; r < n_recs; r++) begin
            run_record(r);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu_subsys.f ====
+incdir+hw
hw/rv_isa_pkg.sv
hw/mem_bus_pkg.sv
hw/base_integer_ctrl_unit.sv
hw/imm_gen.sv
hw/load_store_unit.sv
hw/mem_arbiter.sv
hw/data_mem.sv
hw/lsu_subsys.sv
verif/tb_lsu_subsys.sv

// ==== verif/lsu_input.txt ====
// kind instr rs1 rs2 host_wr host_waddr host_be host_wdata exp_ctrl, rs2 is XORed with LFSR data
// kind 0 decode only, 1 instruction, 2 host access, 3 instruction and host in the same cycle
1 002082B3 00000000 00000000 0 00000000 0 00000000 101
1 00108293 00000000 00000000 0 00000000 0 00000000 109
1 000082E7 00000000 00000000 0 00000000 0 00000000 149
1 00000073 00000000 00000000 0 00000000 0 00000000 009
1 00208063 00000000 00000000 0 00000000 0 00000000 0A0
1 123452B7 00000000 00000000 0 00000000 0 00000000 009
1 00001297 00000000 00000000 0 00000000 0 00000000 009
1 000002EF 00000000 00000000 0 00000000 0 00000000 041
1 0000007F 00000000 00000000 0 00000000 0 00000000 000
0 0000B283 00000000 00000000 0 00000000 0 00000000 01B
0 0020B023 00000000 00000000 0 00000000 0 00000000 00C
2 00000000 00000000 00000000 1 00000040 F 80F17F22 000
2 00000000 00000000 00000000 1 00000041 F 7E01FF93 000
2 00000000 00000000 00000000 1 00000042 F CAFEF00D 000
2 00000000 00000000 00000000 1 00000043 F 13579BDF 000
2 00000000 00000000 00000000 1 00000043 6 AAAAAAAA 000
1 00308283 00000100 00000000 0 00000000 0 00000000 21B
1 0020C283 00000100 00000000 0 00000000 0 00000000 21B
1 00209283 00000100 00000000 0 00000000 0 00000000 41B
1 0040D283 00000100 00000000 0 00000000 0 00000000 41B
1 0040A283 00000100 00000000 0 00000000 0 00000000 61B
1 FF908283 00000108 00000000 0 00000000 0 00000000 21B
1 002085A3 00000100 00000000 0 00000000 0 00000000 20C
1 00209423 00000100 00000000 0 00000000 0 00000000 40C
2 00000000 00000000 00000000 0 00000042 0 00000000 000
1 FE20AC23 00000110 00000000 0 00000000 0 00000000 60C
2 00000000 00000000 00000000 0 00000042 0 00000000 000
3 00C0A283 00000100 00000000 1 00000044 F 2468ACE0 61B
3 0020A823 00000100 00000000 0 00000043 0 00000000 60C
2 00000000 00000000 00000000 0 00000044 0 00000000 000
